// ==== logic/pipe_pkg.sv ====
// Pipeline shared definitions
// Instruction format, opcodes and the payloads passed between stages.
// The payload structs are sized by XLEN_DEFAULT, so a module XLEN
// parameter has to stay equal to XLEN_DEFAULT.
`default_nettype none

package pipe_pkg;

    localparam int NUM_REGS     = 8;    // Register file depth
    localparam int XLEN_DEFAULT = 32;   // Data path width

    typedef logic [2:0] reg_addr_t;     // Register index

    typedef enum logic [2:0] {
        OP_ADD  = 3'd0,
        OP_SUB  = 3'd1,
        OP_AND  = 3'd2,
        OP_XOR  = 3'd3,
        OP_ADDI = 3'd4,
        OP_LOAD = 3'd5
    } op_t;                             // Codes 6 and 7 run as ADD

    // --------------------
    // 16-bit instruction word, rs2 shares bits [6:4] with imm
    typedef struct packed {
        op_t        op;                 // [15:13]
        reg_addr_t  rd;                 // [12:10]
        reg_addr_t  rs1;                // [9:7]
        logic [6:0] imm;                // [6:0] signed immediate
    } instr_t;

    // --------------------
    typedef struct packed {
        op_t                     op;
        reg_addr_t               rd;
        logic [XLEN_DEFAULT-1:0] opr_a;  // Forwarded rs1
        logic [XLEN_DEFAULT-1:0] opr_b;  // Forwarded rs2 or immediate
        instr_t                  instr;  // For trace
    } decoded_t;

    typedef struct packed {
        reg_addr_t               rd;
        logic                    is_load;
        logic [XLEN_DEFAULT-1:0] result;  // ALU value or load address
        instr_t                  instr;
    } executed_t;

endpackage

`default_nettype wire

// ==== logic/gprs.sv ====
// General purpose register file
// Eight entries, two asynchronous read ports, one synchronous write port.
// r0 ignores writes and always reads zero.
`default_nettype none

module gprs #(
    parameter int XLEN = pipe_pkg::XLEN_DEFAULT
) (
    input  wire logic                g_clk,
    input  wire logic                reset,
    input  wire pipe_pkg::reg_addr_t rs1_addr,
    output logic [XLEN-1:0]          rs1_data,
    input  wire pipe_pkg::reg_addr_t rs2_addr,
    output logic [XLEN-1:0]          rs2_data,
    input  wire logic                rd_wen,
    input  wire pipe_pkg::reg_addr_t rd_addr,
    input  wire logic [XLEN-1:0]     rd_wdata
);

    logic [XLEN-1:0] regs [pipe_pkg::NUM_REGS];

    always_ff @(posedge g_clk) begin
        if (reset) begin
            for (int i = 0; i < pipe_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_wen && rd_addr != '0) begin  // Drop r0 writes
            regs[rd_addr] <= rd_wdata;
        end
    end

    // No bypass here, decode forwards the writeback value
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

// ==== logic/pipe_register.sv ====
// Stage register
// Holds one payload and its valid bit between two pipeline stages and
// follows the valid/busy flow control of the pipeline.
`default_nettype none

module pipe_register #(
    parameter type payload_t = logic
) (
    input  wire logic      g_clk,
    input  wire logic      reset,
    input  wire logic      in_valid,
    output logic           in_busy,
    input  wire payload_t  in_data,
    output logic           out_valid,
    input  wire logic      out_busy,
    output payload_t       out_data
);

    logic load;                       // Slot empty or draining

    assign load    = !out_valid || !out_busy;
    assign in_busy = out_valid && out_busy;  // Full and stuck

    always_ff @(posedge g_clk) begin
        if (reset) begin
            out_valid <= 1'b0;
            out_data  <= '0;
        end else if (load) begin
            out_valid <= in_valid;    // Bubble when nothing offered
            out_data  <= in_data;
        end
    end

endmodule

`default_nettype wire

// ==== logic/decode_stage.sv ====
// Decode stage
// Splits the instruction word, reads and forwards the source operands,
// stalls on load-use hazards and builds the payload for execute.
`default_nettype none

module decode_stage #(
    parameter int XLEN = pipe_pkg::XLEN_DEFAULT
) (
    input  wire logic                instr_valid,
    input  wire pipe_pkg::instr_t    instr_data,
    output logic                     instr_busy,
    output pipe_pkg::reg_addr_t      rs1_addr,
    output pipe_pkg::reg_addr_t      rs2_addr,
    input  wire logic [XLEN-1:0]     rs1_rdata,
    input  wire logic [XLEN-1:0]     rs2_rdata,
    input  wire logic                ex_valid,
    input  wire pipe_pkg::reg_addr_t ex_rd,
    input  wire logic                ex_is_load,
    input  wire logic [XLEN-1:0]     ex_result,
    input  wire logic                wb_valid,
    input  wire pipe_pkg::reg_addr_t wb_rd,
    input  wire logic [XLEN-1:0]     wb_wdata,
    input  wire logic                mem_pending,
    input  wire pipe_pkg::reg_addr_t mem_pending_rd,
    output logic                     s2_valid,
    input  wire logic                s2_busy,
    output pipe_pkg::decoded_t       s2_data
);

    logic            use_imm;         // ADDI and LOAD take imm as opr_b
    logic            rs1_nz;
    logic            rs2_nz;
    logic            rs2_used;
    logic            hzd_rs1_ex;
    logic            hzd_rs1_wb;
    logic            hzd_rs2_ex;
    logic            hzd_rs2_wb;
    logic            bubble;
    logic [XLEN-1:0] imm_sext;
    logic [XLEN-1:0] fwd_rs1;
    logic [XLEN-1:0] fwd_rs2;

    // --------------------
    // Field extraction
    assign rs1_addr = instr_data.rs1;
    assign rs2_addr = instr_data.imm[6:4];
    assign imm_sext = {{(XLEN-7){instr_data.imm[6]}}, instr_data.imm};
    assign use_imm  = instr_data.op == pipe_pkg::OP_ADDI ||
                      instr_data.op == pipe_pkg::OP_LOAD;
    assign rs2_used = !use_imm;       // All register-register forms

    // --------------------
    // Hazards against younger stages
    assign rs1_nz     = rs1_addr != '0;
    assign rs2_nz     = rs2_addr != '0;
    assign hzd_rs1_ex = rs1_nz && ex_valid && rs1_addr == ex_rd;
    assign hzd_rs1_wb = rs1_nz && wb_valid && rs1_addr == wb_rd;
    assign hzd_rs2_ex = rs2_nz && ex_valid && rs2_addr == ex_rd;
    assign hzd_rs2_wb = rs2_nz && wb_valid && rs2_addr == wb_rd;

    // Load data not ready yet, hold the instruction in decode
    assign bubble =
        (ex_is_load && (hzd_rs1_ex || (rs2_used && hzd_rs2_ex))) ||
        (mem_pending && rs1_nz && rs1_addr == mem_pending_rd) ||
        (mem_pending && rs2_used && rs2_nz && rs2_addr == mem_pending_rd);

    // Youngest producer wins
    assign fwd_rs1 = (hzd_rs1_ex && !ex_is_load) ? ex_result :
                     hzd_rs1_wb                  ? wb_wdata  :
                                                   rs1_rdata;
    assign fwd_rs2 = (hzd_rs2_ex && !ex_is_load) ? ex_result :
                     hzd_rs2_wb                  ? wb_wdata  :
                                                   rs2_rdata;

    // --------------------
    assign s2_valid   = instr_valid && !bubble;
    assign instr_busy = bubble || s2_busy;

    always_comb begin
        s2_data.op    = instr_data.op;
        s2_data.rd    = instr_data.rd;
        s2_data.opr_a = fwd_rs1;
        s2_data.opr_b = use_imm ? imm_sext : fwd_rs2;
        s2_data.instr = instr_data;   // Carried for trace
    end

endmodule

`default_nettype wire

// ==== logic/execute_stage.sv ====
// Execute stage
// Simple ALU and load address generation. The result is also offered
// back to decode as the youngest forwarding source.
`default_nettype none

module execute_stage #(
    parameter int XLEN = pipe_pkg::XLEN_DEFAULT
) (
    input  wire logic                s2_valid,
    input  wire pipe_pkg::decoded_t  s2_data,
    output pipe_pkg::executed_t      s3_data,
    output logic                     ex_valid,
    output pipe_pkg::reg_addr_t      ex_rd,
    output logic                     ex_is_load,
    output logic [XLEN-1:0]          ex_result
);

    logic [XLEN-1:0] alu_result;

    // LOAD adds opr_a and imm like ADDI
    always_comb begin
        case (s2_data.op)
            pipe_pkg::OP_SUB: alu_result = s2_data.opr_a - s2_data.opr_b;
            pipe_pkg::OP_AND: alu_result = s2_data.opr_a & s2_data.opr_b;
            pipe_pkg::OP_XOR: alu_result = s2_data.opr_a ^ s2_data.opr_b;
            default:          alu_result = s2_data.opr_a + s2_data.opr_b;
        endcase
    end

    // --------------------
    // Forwarding view
    assign ex_valid   = s2_valid;
    assign ex_rd      = s2_data.rd;
    assign ex_is_load = s2_data.op == pipe_pkg::OP_LOAD;  // Value not known yet
    assign ex_result  = alu_result;

    always_comb begin
        s3_data.rd      = s2_data.rd;
        s3_data.is_load = ex_is_load;
        s3_data.result  = alu_result;
        s3_data.instr   = s2_data.instr;
    end

endmodule

`default_nettype wire

// ==== logic/memory_stage.sv ====
// Memory and writeback stage
// Issues one data memory read per load and waits for its response, then
// retires every instruction onto the GPR write port and the trace port.
`default_nettype none

module memory_stage #(
    parameter int XLEN = pipe_pkg::XLEN_DEFAULT
) (
    input  wire logic                 g_clk,
    input  wire logic                 reset,
    input  wire logic                 s3_valid,
    output logic                      s3_busy,
    input  wire pipe_pkg::executed_t  s3_data,
    input  wire pipe_pkg::instr_t     s3_instr,
    output logic                      dmem_req,
    output logic [XLEN-1:0]           dmem_addr,
    input  wire logic                 dmem_recv,
    input  wire logic [XLEN-1:0]      dmem_rdata,
    output logic                      mem_pending,
    output pipe_pkg::reg_addr_t       mem_pending_rd,
    output logic                      wb_valid,
    output pipe_pkg::reg_addr_t       wb_rd,
    output logic [XLEN-1:0]           wb_wdata,
    output logic                      trs_valid,
    output pipe_pkg::reg_addr_t       trs_rd,
    output logic [XLEN-1:0]           trs_wdata,
    output pipe_pkg::instr_t          trs_instr
);

    logic issued;                     // Request out for current load
    logic is_load;
    logic load_done;
    logic retire;

    assign is_load   = s3_valid && s3_data.is_load;
    assign load_done = issued && dmem_recv;

    // --------------------
    // Data memory request
    assign dmem_req  = is_load && !issued;  // Single pulse per load
    assign dmem_addr = s3_data.result;

    always_ff @(posedge g_clk) begin
        if (reset) begin
            issued <= 1'b0;
        end else if (load_done) begin
            issued <= 1'b0;           // Ready for the next load
        end else if (dmem_req) begin
            issued <= 1'b1;
        end
    end

    // Hold the stage until the read data comes back
    assign s3_busy        = is_load && !load_done;
    assign mem_pending    = s3_busy;
    assign mem_pending_rd = s3_data.rd;

    // --------------------
    // Retire, writeback and trace share one event
    assign retire    = s3_valid && (!s3_data.is_load || load_done);
    assign wb_valid  = retire;
    assign wb_rd     = s3_data.rd;
    assign wb_wdata  = s3_data.is_load ? dmem_rdata : s3_data.result;

    assign trs_valid = retire;
    assign trs_rd    = s3_data.rd;
    assign trs_wdata = wb_wdata;
    assign trs_instr = s3_instr;

endmodule

`default_nettype wire

// ==== logic/pipeline_top.sv ====
// Integer pipeline top level
// Decode, execute and memory/writeback joined by two stage registers,
// with the register file read in decode and written at retire.
`default_nettype none

module pipeline_top #(
    parameter int XLEN = pipe_pkg::XLEN_DEFAULT
) (
    input  wire logic              g_clk,
    input  wire logic              reset,
    input  wire logic              instr_valid,
    input  wire pipe_pkg::instr_t  instr_data,
    output logic                   instr_busy,
    output logic                   dmem_req,
    output logic [XLEN-1:0]        dmem_addr,
    input  wire logic              dmem_recv,
    input  wire logic [XLEN-1:0]   dmem_rdata,
    output logic                   trs_valid,
    output pipe_pkg::reg_addr_t    trs_rd,
    output logic [XLEN-1:0]        trs_wdata,
    output pipe_pkg::instr_t       trs_instr
);

    pipe_pkg::reg_addr_t  rs1_addr;
    pipe_pkg::reg_addr_t  rs2_addr;
    logic [XLEN-1:0]      rs1_rdata;
    logic [XLEN-1:0]      rs2_rdata;
    logic                 d_valid;         // Decode into first register
    logic                 d_busy;
    pipe_pkg::decoded_t   d_data;
    logic                 s2_valid;        // Execute stage
    logic                 s2_busy;
    pipe_pkg::decoded_t   s2_data;
    pipe_pkg::executed_t  x_data;          // Execute into second register
    logic                 s3_valid;        // Memory stage
    logic                 s3_busy;
    pipe_pkg::executed_t  s3_data;
    logic                 ex_valid;
    pipe_pkg::reg_addr_t  ex_rd;
    logic                 ex_is_load;
    logic [XLEN-1:0]      ex_result;
    logic                 wb_valid;        // Also the GPR write port
    pipe_pkg::reg_addr_t  wb_rd;
    logic [XLEN-1:0]      wb_wdata;
    logic                 mem_pending;
    pipe_pkg::reg_addr_t  mem_pending_rd;

    // --------------------
    gprs #(.XLEN(XLEN)) i_gprs (
        .g_clk    (g_clk),
        .reset    (reset),
        .rs1_addr (rs1_addr),
        .rs1_data (rs1_rdata),
        .rs2_addr (rs2_addr),
        .rs2_data (rs2_rdata),
        .rd_wen   (wb_valid),
        .rd_addr  (wb_rd),
        .rd_wdata (wb_wdata)
    );

    decode_stage #(.XLEN(XLEN)) i_s1_decode (
        .s2_valid (d_valid),
        .s2_busy  (d_busy),
        .s2_data  (d_data),
        .*
    );

    pipe_register #(.payload_t(pipe_pkg::decoded_t)) i_s2_register (
        .g_clk     (g_clk),
        .reset     (reset),
        .in_valid  (d_valid),
        .in_busy   (d_busy),
        .in_data   (d_data),
        .out_valid (s2_valid),
        .out_busy  (s2_busy),
        .out_data  (s2_data)
    );

    execute_stage #(.XLEN(XLEN)) i_s2_execute (
        .s3_data (x_data),
        .*
    );

    pipe_register #(.payload_t(pipe_pkg::executed_t)) i_s3_register (
        .g_clk     (g_clk),
        .reset     (reset),
        .in_valid  (s2_valid),
        .in_busy   (s2_busy),
        .in_data   (x_data),
        .out_valid (s3_valid),
        .out_busy  (s3_busy),
        .out_data  (s3_data)
    );

    memory_stage #(.XLEN(XLEN)) i_s3_memory (
        .s3_instr (s3_data.instr),
        .*
    );

endmodule

`default_nettype wire

// ==== bench/pipeline_tb.sv ====
// Integer pipeline testbench
// Random instruction stream with frequent loads and dependencies, a data
// memory responder with random latency, and an in-order reference model
// that checks every retired instruction and every load address.
`default_nettype none

module pipeline_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int          XLEN         = pipe_pkg::XLEN_DEFAULT;
    localparam int          CLK_PERIOD   = 8;
    localparam int          SAMPLE_DELAY = 3;          // 1 ns before rising edge
    localparam int          RESET_CYCLES = 5;
    localparam int          TIMEOUT      = 200;        // Cycles per wait
    localparam int          IDLE_CYCLES  = 8;          // Window after drain
    localparam int          N_INSTR      = 500;
    localparam int          MAX_CYCLES   = N_INSTR * 40;
    localparam logic [31:0] SEED         = 32'hc2efae69;
    localparam logic [31:0] DATA_MASK    = 32'h5a5a_1234;

    logic                 g_clk;
    logic                 reset;
    logic                 instr_valid;
    pipe_pkg::instr_t     instr_data;
    logic                 instr_busy;
    logic                 dmem_req;
    logic [XLEN-1:0]      dmem_addr;
    logic                 dmem_recv;
    logic [XLEN-1:0]      dmem_rdata;
    logic                 trs_valid;
    pipe_pkg::reg_addr_t  trs_rd;
    logic [XLEN-1:0]      trs_wdata;
    pipe_pkg::instr_t     trs_instr;

    // --------------------
    // Reference model and responder state
    pipe_pkg::instr_t     pending_q [$];               // Accepted, not retired
    logic [XLEN-1:0]      model_regs [pipe_pkg::NUM_REGS];
    int unsigned          accepted;
    int unsigned          retired;
    pipe_pkg::reg_addr_t  last_rd;                     // Feeds back-to-back deps
    logic                 hold;                        // Offered word not taken
    int                   stall_cycles;
    int                   quiet_cycles;
    logic                 resp_pending;
    int                   resp_delay;
    logic [XLEN-1:0]      resp_addr;

    pipeline_top #(.XLEN(XLEN)) uut (
        .g_clk       (g_clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr_data  (instr_data),
        .instr_busy  (instr_busy),
        .dmem_req    (dmem_req),
        .dmem_addr   (dmem_addr),
        .dmem_recv   (dmem_recv),
        .dmem_rdata  (dmem_rdata),
        .trs_valid   (trs_valid),
        .trs_rd      (trs_rd),
        .trs_wdata   (trs_wdata),
        .trs_instr   (trs_instr)
    );

    initial begin
        g_clk = 1'b0;
        forever #(CLK_PERIOD / 2) g_clk = ~g_clk;
    end

    // --------------------
    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            abort_run($sformatf("mismatch %s: expected %b, actual %b", name, expected, actual));
        end
    endtask

    task automatic check_word(input string name, input logic [XLEN-1:0] expected,
                              input logic [XLEN-1:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("mismatch %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    task automatic check_rd(input string name, input pipe_pkg::reg_addr_t expected,
                            input pipe_pkg::reg_addr_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("mismatch %s: expected r%0d, actual r%0d", name, expected, actual));
        end
    endtask

    task automatic check_instr(input string name, input pipe_pkg::instr_t expected,
                               input pipe_pkg::instr_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("mismatch %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    // --------------------
    function automatic logic [XLEN-1:0] sext_imm(input logic [6:0] imm);
        return {{(XLEN-7){imm[6]}}, imm};
    endfunction

    // Address XOR mask, then rotate left by 3
    function automatic logic [XLEN-1:0] load_response(input logic [XLEN-1:0] addr);
        logic [XLEN-1:0] mixed;
        mixed = addr ^ DATA_MASK;
        return {mixed[XLEN-4:0], mixed[XLEN-1:XLEN-3]};
    endfunction

    // Architectural result from the model registers
    function automatic logic [XLEN-1:0] model_result(input pipe_pkg::instr_t instr);
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] res;
        a = model_regs[instr.rs1];
        b = model_regs[instr.imm[6:4]];                // rs2 field
        case (instr.op)
            pipe_pkg::OP_SUB:  res = a - b;
            pipe_pkg::OP_AND:  res = a & b;
            pipe_pkg::OP_XOR:  res = a ^ b;
            pipe_pkg::OP_ADDI: res = a + sext_imm(instr.imm);
            pipe_pkg::OP_LOAD: res = load_response(a + sext_imm(instr.imm));
            default:           res = a + b;            // ADD and spare codes
        endcase
        return res;
    endfunction

    // Weighted opcodes, sources often taken from the previous rd
    function automatic pipe_pkg::instr_t next_instr();
        logic [31:0]         pick;
        logic [31:0]         bits;
        logic [2:0]          op;
        pipe_pkg::reg_addr_t rd;
        pipe_pkg::reg_addr_t rs1;
        logic [6:0]          imm;
        pick = $urandom % 100;
        bits = $urandom;
        if (pick < 25)      op = pipe_pkg::OP_LOAD;
        else if (pick < 45) op = pipe_pkg::OP_ADDI;
        else if (pick < 58) op = pipe_pkg::OP_ADD;
        else if (pick < 68) op = pipe_pkg::OP_SUB;
        else if (pick < 78) op = pipe_pkg::OP_AND;
        else if (pick < 92) op = pipe_pkg::OP_XOR;
        else                op = {2'b11, bits[31]};    // Spare codes 6 and 7
        rd  = bits[17:15];
        rs1 = bits[3] ? last_rd : bits[6:4];
        imm = bits[13:7];
        if (bits[14]) begin
            imm[6:4] = last_rd;                        // rs2 depends on last rd
        end
        last_rd = rd;
        return {op, rd, rs1, imm};
    endfunction

    // --------------------
    // One cycle: drive after the falling edge, sample just before the rising edge
    task automatic drive_inputs(input logic offer);
        logic [31:0] roll;
        dmem_recv  = 1'b0;
        dmem_rdata = $urandom;                         // Junk outside a response
        if (resp_pending) begin
            resp_delay--;
            if (resp_delay == 0) begin
                dmem_recv    = 1'b1;
                dmem_rdata   = load_response(resp_addr);
                resp_pending = 1'b0;
            end
        end
        if (!hold) begin
            roll        = $urandom % 10;
            instr_valid = offer && roll < 7;           // About 70 percent
            if (instr_valid) begin
                instr_data = next_instr();
            end
        end
    endtask

    task automatic sample_outputs();
        pipe_pkg::instr_t head;
        logic [XLEN-1:0]  value;
        if (trs_valid) begin
            if (pending_q.size() == 0) begin
                abort_run("an instruction retired while none was outstanding");
            end
            head  = pending_q.pop_front();
            value = model_result(head);
            check_instr($sformatf("retire %0d instr", retired), head, trs_instr);
            check_rd($sformatf("retire %0d rd", retired), head.rd, trs_rd);
            check_word($sformatf("retire %0d wdata", retired), value, trs_wdata);
            if (head.rd != '0) begin
                model_regs[head.rd] = value;           // r0 stays zero
            end
            retired++;
        end
        if (dmem_req) begin
            if (resp_pending || pending_q.size() == 0) begin
                abort_run("a data memory request came with no load waiting for one");
            end
            head = pending_q[0];                       // Load is the oldest
            if (head.op != pipe_pkg::OP_LOAD) begin
                abort_run("a data memory request came for an instruction that is not a load");
            end
            check_word($sformatf("load %0d address", retired),
                       model_regs[head.rs1] + sext_imm(head.imm), dmem_addr);
            resp_pending = 1'b1;
            resp_delay   = 1 + ($urandom % 4);
            resp_addr    = dmem_addr;
        end
        if (instr_valid && !instr_busy) begin
            pending_q.push_back(instr_data);
            accepted++;
            hold         = 1'b0;
            stall_cycles = 0;
        end else begin
            hold         = instr_valid;
            stall_cycles = instr_valid ? stall_cycles + 1 : 0;
        end
        quiet_cycles = (pending_q.size() != 0 && !trs_valid) ? quiet_cycles + 1 : 0;
        if (stall_cycles > TIMEOUT) begin
            abort_run("the instruction input stayed busy for 200 cycles");
        end
        if (quiet_cycles > TIMEOUT) begin
            abort_run("no instruction retired for 200 cycles");
        end
    endtask

    task automatic run_cycle(input logic offer);
        @(negedge g_clk);
        drive_inputs(offer);
        #(SAMPLE_DELAY);
        sample_outputs();
    endtask

    // --------------------
    initial begin : stimulus
        int cycles;
        void'($urandom(SEED));
        reset        = 1'b1;
        instr_valid  = 1'b0;
        instr_data   = '0;
        dmem_recv    = 1'b0;
        dmem_rdata   = '0;
        accepted     = 0;
        retired      = 0;
        last_rd      = '0;
        hold         = 1'b0;
        stall_cycles = 0;
        quiet_cycles = 0;
        resp_pending = 1'b0;
        resp_delay   = 0;
        resp_addr    = '0;
        for (int i = 0; i < pipe_pkg::NUM_REGS; i++) begin
            model_regs[i] = '0;
        end

        repeat (RESET_CYCLES) begin
            @(negedge g_clk);
            check_bit("reset instr_busy", 1'b0, instr_busy);
            check_bit("reset dmem_req", 1'b0, dmem_req);
            check_bit("reset trs_valid", 1'b0, trs_valid);
        end
        reset = 1'b0;
        run_cycle(1'b0);
        check_bit("post reset instr_busy", 1'b0, instr_busy);
        check_bit("post reset dmem_req", 1'b0, dmem_req);
        check_bit("post reset trs_valid", 1'b0, trs_valid);

        cycles = 0;
        while (accepted < N_INSTR) begin
            run_cycle(1'b1);
            cycles++;
            if (cycles > MAX_CYCLES) begin
                abort_run("the instruction stream did not finish in time");
            end
        end

        // Drain what is still in flight
        cycles = 0;
        while (pending_q.size() != 0 || resp_pending || hold) begin
            run_cycle(1'b0);
            cycles++;
            if (cycles > TIMEOUT) begin
                abort_run("the pipeline did not drain within 200 cycles");
            end
        end

        // Empty pipeline, any late retire or request is a duplicate
        repeat (IDLE_CYCLES) begin
            run_cycle(1'b0);
        end
        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
logic/pipe_pkg.sv
logic/gprs.sv
logic/pipe_register.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/pipeline_top.sv
bench/pipeline_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= pipeline_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -q '^No errors$$'

clean:
	rm -rf $(OBJ_DIR)
